/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = rv64_core_tb
FILELIST  = rv64_core.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/rv64_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module rv64_core_tb;

    localparam int        PERIOD       = 40;
    localparam int        RESET_CYCLES = 2;
    localparam int        MAX_ROWS     = 64;
    localparam logic [6:0] OP_LOAD     = 7'b0000011;
    localparam logic [6:0] OP_IMM      = 7'b0010011;
    localparam logic [6:0] OP_IMM_W    = 7'b0011011;
    localparam logic [6:0] OP_REG      = 7'b0110011;
    localparam logic [6:0] OP_REG_W    = 7'b0111011;
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_JALR     = 7'b1100111;

    logic                   sys_clk;
    logic                   rst_n;
    logic [31:0]            inst;
    logic [`RV64_XLEN-1:0]  mem_rd_data;
    logic [`RV64_XLEN-1:0]  pc;
    logic                   mem_rd_en;
    logic                   mem_wen;
    logic [`RV64_XLEN-1:0]  mem_addr;
    logic [`RV64_XLEN-1:0]  mem_wr_data;
    logic [7:0]             mem_wr_mask;

    logic [31:0]            imem [128];
    logic [63:0]            dmem [64];
    logic [63:0]            exp_pc [MAX_ROWS];
    logic                   exp_wen [MAX_ROWS];
    logic                   exp_rd [MAX_ROWS];
    logic [63:0]            exp_addr [MAX_ROWS];
    logic [63:0]            exp_wdata [MAX_ROWS];
    logic [7:0]             exp_mask [MAX_ROWS];
    int                     n_rows;
    logic [63:0]            cur_pc;
    logic [63:0]            d_init;
    logic [63:0]            lnk;
    logic [63:0]            boot_pc;
    logic [31:0]            boot_word;
    logic                   table_ready;
    integer                 seed;

    rv64_core dut_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .mem_rd_data (mem_rd_data),
        .pc          (pc),
        .mem_rd_en   (mem_rd_en),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr_mask (mem_wr_mask)
    );

    initial sys_clk = 1'b0;
    always #(PERIOD / 2) sys_clk = ~sys_clk;

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////
    assign inst        = imem[pc[8:2]];
    assign mem_rd_data = dmem[mem_addr[8:3]];

    // Byte-masked doubleword write
    always @(posedge sys_clk) begin
        if (mem_wen) begin
            for (int b = 0; b < 8; b++) begin
                if (mem_wr_mask[b]) begin
                    dmem[mem_addr[8:3]][8*b +: 8] <= mem_wr_data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    ////////////////////////////////////////
    // Program and expectation builders
    ////////////////////////////////////////
    task automatic add_row(input logic [31:0] word, input logic [63:0] nxt, input logic wen,
                           input logic rd, input logic [63:0] addr, input logic [63:0] wdata,
                           input logic [7:0] mask);
        imem[cur_pc[8:2]]  = word;
        exp_pc[n_rows]     = cur_pc;
        exp_wen[n_rows]    = wen;
        exp_rd[n_rows]     = rd;
        exp_addr[n_rows]   = addr;
        exp_wdata[n_rows]  = wdata;
        exp_mask[n_rows]   = mask;
        n_rows++;
        cur_pc = nxt;
    endtask

    task automatic plain_step(input logic [31:0] word);
        add_row(word, cur_pc + 4, 1'b0, 1'b0, '0, '0, 8'h00);
    endtask

    task automatic store_step(input logic [31:0] word, input logic [63:0] addr,
                              input logic [63:0] wdata, input logic [7:0] mask);
        add_row(word, cur_pc + 4, 1'b1, 1'b0, addr, wdata, mask);
    endtask

    task automatic store_dword(input logic [4:0] rs2, input logic [11:0] off,
                               input logic [63:0] val);
        store_step(s_type(off, rs2, 5'd0, 3'b011), {52'h0, off}, val, 8'hFF);
    endtask

    task automatic load_step(input logic [2:0] f3, input logic [4:0] rd,
                             input logic [11:0] off);
        add_row(i_type(off, 5'd0, f3, rd, OP_LOAD), cur_pc + 4, 1'b0, 1'b1,
                {52'h0, off}, '0, 8'h00);
    endtask

    task automatic branch_step(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken);
        add_row(b_type(13'd8, rs2, rs1, f3), taken ? cur_pc + 8 : cur_pc + 4,
                1'b0, 1'b0, '0, '0, 8'h00);
    endtask

    task automatic build_program;
        // x1 = -5, x2 = 3
        plain_step(i_type(12'hFFB, 5'd0, 3'b000, 5'd1, OP_IMM));
        plain_step(i_type(12'd3, 5'd0, 3'b000, 5'd2, OP_IMM));
        plain_step(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG));
        store_dword(5'd3, 12'h100, 64'hFFFF_FFFF_FFFF_FFF8);
        plain_step(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd4, OP_REG));
        store_dword(5'd4, 12'h108, 64'hFFFF_FFFF_FFFF_FFFF);
        plain_step(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd5, OP_REG));
        store_dword(5'd5, 12'h110, 64'd1);
        plain_step({20'h7FFFF, 5'd6, OP_LUI});
        // ADDW overflows into bit 31 and must sign-extend
        plain_step(r_type(7'h00, 5'd6, 5'd6, 3'b000, 5'd7, OP_REG_W));
        store_dword(5'd7, 12'h118, 64'hFFFF_FFFF_FFFF_E000);
        plain_step(i_type(12'd30, 5'd2, 3'b001, 5'd8, OP_IMM_W));
        store_dword(5'd8, 12'h120, 64'hFFFF_FFFF_C000_0000);

        ////////////////////////////////////////
        // Loads from the doubleword at 0x40
        load_step(3'b000, 5'd9, 12'h043);
        store_dword(5'd9, 12'h128, {{56{d_init[31]}}, d_init[31:24]});
        load_step(3'b101, 5'd10, 12'h046);
        store_dword(5'd10, 12'h130, {48'h0, d_init[63:48]});
        load_step(3'b010, 5'd11, 12'h044);
        store_dword(5'd11, 12'h138, {{32{d_init[63]}}, d_init[63:32]});
        load_step(3'b011, 5'd12, 12'h040);
        store_dword(5'd12, 12'h140, d_init);
        load_step(3'b100, 5'd13, 12'h045);
        store_dword(5'd13, 12'h148, {56'h0, d_init[47:40]});
        load_step(3'b001, 5'd14, 12'h042);
        store_dword(5'd14, 12'h150, {{48{d_init[31]}}, d_init[31:16]});
        load_step(3'b110, 5'd15, 12'h040);
        store_dword(5'd15, 12'h158, {32'h0, d_init[31:0]});

        // Narrow stores, lanes replicated and masked by offset
        store_step(s_type(12'h163, 5'd1, 5'd0, 3'b000), 64'h163, {8{8'hFB}}, 8'h08);
        store_step(s_type(12'h16A, 5'd6, 5'd0, 3'b001), 64'h16A, {4{16'hF000}}, 8'h0C);
        store_step(s_type(12'h174, 5'd3, 5'd0, 3'b010), 64'h174, {2{32'hFFFF_FFF8}}, 8'hF0);
        store_step(s_type(12'h178, 5'd2, 5'd0, 3'b011), 64'h178, 64'd3, 8'hFF);

        ////////////////////////////////////////
        // Branches, each kind taken and not taken
        branch_step(3'b000, 5'd2, 5'd2, 1'b1);
        branch_step(3'b000, 5'd1, 5'd2, 1'b0);
        branch_step(3'b001, 5'd2, 5'd2, 1'b0);
        branch_step(3'b001, 5'd1, 5'd2, 1'b1);
        branch_step(3'b100, 5'd1, 5'd2, 1'b1);
        branch_step(3'b100, 5'd2, 5'd1, 1'b0);
        branch_step(3'b101, 5'd1, 5'd2, 1'b0);
        branch_step(3'b101, 5'd2, 5'd1, 1'b1);
        branch_step(3'b110, 5'd1, 5'd2, 1'b0);
        branch_step(3'b110, 5'd2, 5'd1, 1'b1);
        branch_step(3'b111, 5'd1, 5'd2, 1'b1);
        branch_step(3'b111, 5'd2, 5'd1, 1'b0);

        lnk = cur_pc + 4;
        add_row(j_type(21'd8, 5'd16), cur_pc + 8, 1'b0, 1'b0, '0, '0, 8'h00);
        store_dword(5'd16, 12'h188, lnk);
        // JALR to an odd address lands on the even one below
        plain_step(i_type(cur_pc[11:0] + 12'd12, 5'd0, 3'b000, 5'd18, OP_IMM));
        lnk = cur_pc + 4;
        add_row(i_type(12'd1, 5'd18, 3'b000, 5'd17, OP_JALR), cur_pc + 8,
                1'b0, 1'b0, '0, '0, 8'h00);
        store_dword(5'd17, 12'h190, lnk);

        plain_step(i_type(12'd7, 5'd0, 3'b000, 5'd0, OP_IMM));
        store_dword(5'd0, 12'h198, 64'd0);
        plain_step(32'h0000_007F);
        // Unknown opcode falls through to the next word
        store_dword(5'd0, 12'h1A0, 64'd0);
    endtask

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [63:0] expv,
                               input logic [63:0] actv);
        if (expv !== actv) begin
            $display("mismatch %s: expected %h, actual %h", name, expv, actv);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        wait (table_ready);
        #((n_rows + RESET_CYCLES + 10) * PERIOD);
        $display("Timeout: the program did not finish in the expected time");
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        rst_n       = 1'b0;
        seed        = 32'hb8b0;
        table_ready = 1'b0;
        n_rows      = 0;
        cur_pc      = `RV64_RESET_PC;
        boot_pc     = `RV64_RESET_PC;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {$random(seed), $random(seed)};
        end
        for (int i = 0; i < 128; i++) begin
            imem[i] = 32'h0;
        end
        d_init = dmem[8];
        build_program();
        table_ready = 1'b1;

        // A load, then a store, sits at the reset PC while reset is held
        boot_word = imem[boot_pc[8:2]];
        for (int c = 0; c < RESET_CYCLES; c++) begin
            if (c == 0) begin
                imem[boot_pc[8:2]] = i_type(12'h040, 5'd0, 3'b011, 5'd0, OP_LOAD);
            end else begin
                imem[boot_pc[8:2]] = s_type(12'h1A8, 5'd0, 5'd0, 3'b011);
            end
            @(posedge sys_clk);
            #2;
            check_value("pc", `RV64_RESET_PC, pc);
            check_value("mem_wen", 64'd0, {63'd0, mem_wen});
            check_value("mem_rd_en", 64'd0, {63'd0, mem_rd_en});
        end
        imem[boot_pc[8:2]] = boot_word;
        rst_n = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            // Sample just before the retiring edge
            #(PERIOD - 4);
            check_value("pc", exp_pc[r], pc);
            check_value("mem_wen", {63'd0, exp_wen[r]}, {63'd0, mem_wen});
            check_value("mem_rd_en", {63'd0, exp_rd[r]}, {63'd0, mem_rd_en});
            check_value("mem_wr_mask", {56'd0, exp_mask[r]}, {56'd0, mem_wr_mask});
            if (exp_wen[r] || exp_rd[r]) begin
                check_value("mem_addr", exp_addr[r], mem_addr);
            end
            if (exp_wen[r]) begin
                check_value("mem_wr_data", exp_wdata[r], mem_wr_data);
            end
            @(posedge sys_clk);
            #2;
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module alu (
    input  wire  [`RV64_XLEN-1:0]   pc,
    input  wire  [`RV64_XLEN-1:0]   rs1_data,
    input  wire  [`RV64_XLEN-1:0]   rs2_data,
    input  wire  [`RV64_XLEN-1:0]   imm,
    input  wire rv64_pkg::op1_sel_e op1_sel,
    input  wire rv64_pkg::op2_sel_e op2_sel,
    input  wire rv64_pkg::alu_op_e  alu_op,
    input  wire                     alu_word,
    output logic [`RV64_XLEN-1:0]   alu_result
);
    import rv64_pkg::*;

    logic [`RV64_XLEN-1:0] op1;
    logic [`RV64_XLEN-1:0] op2;
    logic [`RV64_XLEN-1:0] srl_src;
    logic [`RV64_XLEN-1:0] sra_src;
    logic [`RV64_XLEN-1:0] result_full;
    logic [5:0]            shamt;

    ////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////
    always_comb begin
        case (op1_sel)
            OP1_PC:   op1 = pc;
            OP1_ZERO: op1 = '0;
            default:  op1 = rs1_data;
        endcase
    end

    assign op2 = (op2_sel == OP2_IMM) ? imm : rs2_data;

    // Word shifts use 5 bits and start from the low half
    assign shamt   = alu_word ? {1'b0, op2[4:0]} : op2[5:0];
    assign srl_src = alu_word ? {{(`RV64_XLEN-32){1'b0}}, op1[31:0]} : op1;
    assign sra_src = alu_word ? {{(`RV64_XLEN-32){op1[31]}}, op1[31:0]} : op1;

    ////////////////////////////////////////
    // Operation
    ////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_ADD:  result_full = op1 + op2;
            ALU_SUB:  result_full = op1 - op2;
            ALU_SLL:  result_full = op1 << shamt;
            ALU_SLT:  result_full = {{(`RV64_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: result_full = {{(`RV64_XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:  result_full = op1 ^ op2;
            ALU_SRL:  result_full = srl_src >> shamt;
            ALU_SRA:  result_full = $signed(sra_src) >>> shamt;
            ALU_OR:   result_full = op1 | op2;
            default:  result_full = op1 & op2;
        endcase
    end

    // W forms sign-extend the low 32 bits
    assign alu_result = alu_word ? {{(`RV64_XLEN-32){result_full[31]}}, result_full[31:0]}
                                 : result_full;

endmodule

`default_nettype wire

/* hdl/decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module decoder (
    input  wire                                 rst_n,
    input  wire  [31:0]                         inst,
    input  wire  [`RV64_XLEN-1:0]               rs1_data,
    input  wire  [`RV64_XLEN-1:0]               rs2_data,
    output logic [$clog2(`RV64_NUM_REGS)-1:0]   rs1_addr,
    output logic [$clog2(`RV64_NUM_REGS)-1:0]   rs2_addr,
    output logic [$clog2(`RV64_NUM_REGS)-1:0]   rd_addr,
    output logic [`RV64_XLEN-1:0]               imm,
    output rv64_pkg::alu_op_e                   alu_op,
    output logic                                alu_word,
    output rv64_pkg::op1_sel_e                  op1_sel,
    output rv64_pkg::op2_sel_e                  op2_sel,
    output rv64_pkg::pc_sel_e                   pc_sel,
    output logic                                take_branch,
    output logic                                reg_wen,
    output logic                                mem_rd_en,
    output logic                                mem_wen,
    output logic [2:0]                          mem_funct3,
    output rv64_pkg::wb_sel_e                   wb_sel
);
    import rv64_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`RV64_XLEN-1:0] imm_i;
    logic [`RV64_XLEN-1:0] imm_s;
    logic [`RV64_XLEN-1:0] imm_b;
    logic [`RV64_XLEN-1:0] imm_u;
    logic [`RV64_XLEN-1:0] imm_j;
    logic                  branch_cond;
    logic                  branch_ok;
    logic                  shift_imm_ok;
    logic                  alt_ok;
    logic                  op_ok;
    logic                  word_f3_ok;
    logic                  shift_alt;

    // funct3 to ALU operation, alt picks SUB or SRA
    function automatic alu_op_e f3_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // Fields and immediates
    ////////////////////////////////////////
    assign opcode     = opcode_e'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign rs1_addr   = inst[19:15];
    assign rs2_addr   = inst[24:20];
    assign rd_addr    = inst[11:7];
    assign mem_funct3 = funct3;

    assign imm_i = {{(`RV64_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`RV64_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`RV64_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {{(`RV64_XLEN-32){inst[31]}}, inst[31:12], 12'h000};
    assign imm_j = {{(`RV64_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    ////////////////////////////////////////
    // Branch compare and encoding checks
    ////////////////////////////////////////
    always_comb begin
        branch_ok = 1'b1;
        case (funct3)
            3'b000: branch_cond = rs1_data == rs2_data;
            3'b001: branch_cond = rs1_data != rs2_data;
            3'b100: branch_cond = $signed(rs1_data) < $signed(rs2_data);
            3'b101: branch_cond = $signed(rs1_data) >= $signed(rs2_data);
            3'b110: branch_cond = rs1_data < rs2_data;
            3'b111: branch_cond = rs1_data >= rs2_data;
            default: begin
                branch_cond = 1'b0;
                branch_ok   = 1'b0;
            end
        endcase
    end

    // 64-bit immediate shifts keep bit 25 for shamt[5]
    always_comb begin
        case (funct3)
            3'b001:  shift_imm_ok = inst[31:26] == 6'b000000;
            3'b101:  shift_imm_ok = inst[31:26] == 6'b000000 || inst[31:26] == 6'b010000;
            default: shift_imm_ok = 1'b1;
        endcase
    end

    assign alt_ok     = funct3 == 3'b000 || funct3 == 3'b101;
    assign op_ok      = funct7 == 7'b0000000 || (funct7 == 7'b0100000 && alt_ok);
    assign word_f3_ok = funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101;
    assign shift_alt  = funct3 == 3'b101 && inst[30];

    ////////////////////////////////////////
    // Control set per opcode
    ////////////////////////////////////////
    always_comb begin
        imm         = imm_i;
        alu_op      = ALU_ADD;
        alu_word    = 1'b0;
        op1_sel     = OP1_RS1;
        op2_sel     = OP2_IMM;
        pc_sel      = PC_PLUS4;
        take_branch = 1'b0;
        reg_wen     = 1'b0;
        mem_rd_en   = 1'b0;
        mem_wen     = 1'b0;
        wb_sel      = WB_ALU;
        case (opcode)
            OPC_LUI: begin
                imm     = imm_u;
                op1_sel = OP1_ZERO;
                reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                imm     = imm_u;
                op1_sel = OP1_PC;
                reg_wen = 1'b1;
            end
            OPC_JAL: begin
                imm         = imm_j;
                op1_sel     = OP1_PC;
                pc_sel      = PC_TARGET;
                take_branch = 1'b1;
                wb_sel      = WB_PC4;
                reg_wen     = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    pc_sel  = PC_JALR;
                    wb_sel  = WB_PC4;
                    reg_wen = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (branch_ok) begin
                    imm         = imm_b;
                    op1_sel     = OP1_PC;
                    pc_sel      = PC_TARGET;
                    take_branch = branch_cond;
                end
            end
            OPC_LOAD: begin
                if (funct3 != 3'b111) begin
                    mem_rd_en = 1'b1;
                    wb_sel    = WB_LOAD;
                    reg_wen   = 1'b1;
                end
            end
            OPC_STORE: begin
                if (!funct3[2]) begin
                    imm     = imm_s;
                    mem_wen = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (shift_imm_ok) begin
                    alu_op  = f3_alu_op(funct3, shift_alt);
                    reg_wen = 1'b1;
                end
            end
            OPC_OP_IMM_32: begin
                if (word_f3_ok && (funct3 == 3'b000 || op_ok)) begin
                    alu_op   = f3_alu_op(funct3, shift_alt);
                    alu_word = 1'b1;
                    reg_wen  = 1'b1;
                end
            end
            OPC_OP: begin
                if (op_ok) begin
                    alu_op  = f3_alu_op(funct3, inst[30]);
                    op2_sel = OP2_RS2;
                    reg_wen = 1'b1;
                end
            end
            OPC_OP_32: begin
                if (word_f3_ok && op_ok) begin
                    alu_op   = f3_alu_op(funct3, inst[30]);
                    alu_word = 1'b1;
                    op2_sel  = OP2_RS2;
                    reg_wen  = 1'b1;
                end
            end
            default: begin
                // Unknown encoding retires as a no-op
                reg_wen = 1'b0;
            end
        endcase
        // No architectural writes while in reset
        if (!rst_n) begin
            reg_wen   = 1'b0;
            mem_rd_en = 1'b0;
            mem_wen   = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/gpr_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module gpr_file (
    input  wire                                 sys_clk,
    input  wire                                 rst_n,
    input  wire  [$clog2(`RV64_NUM_REGS)-1:0]   rs1_addr,
    input  wire  [$clog2(`RV64_NUM_REGS)-1:0]   rs2_addr,
    input  wire  [$clog2(`RV64_NUM_REGS)-1:0]   rd_addr,
    input  wire  [`RV64_XLEN-1:0]               wr_data,
    input  wire                                 reg_wen,
    output logic [`RV64_XLEN-1:0]               rs1_data,
    output logic [`RV64_XLEN-1:0]               rs2_data
);

    logic [`RV64_XLEN-1:0] regs [`RV64_NUM_REGS];

    // Entry 0 is cleared at reset and never written, so x0 stays zero
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV64_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen && rd_addr != '0) begin
            regs[rd_addr] <= wr_data;
        end
    end

    // Both read ports are asynchronous
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* hdl/mem_writeback.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module mem_writeback (
    input  wire  [`RV64_XLEN-1:0]   alu_result,
    input  wire  [`RV64_XLEN-1:0]   rs2_data,
    input  wire  [`RV64_XLEN-1:0]   pc_plus4,
    input  wire  [`RV64_XLEN-1:0]   mem_rd_data,
    input  wire  [2:0]              mem_funct3,
    input  wire                     mem_wen,
    input  wire rv64_pkg::wb_sel_e  wb_sel,
    output logic [`RV64_XLEN-1:0]   mem_wr_data,
    output logic [7:0]              mem_wr_mask,
    output logic [`RV64_XLEN-1:0]   wr_data
);
    import rv64_pkg::*;

    logic [2:0]            byte_off;
    logic [7:0]            size_mask;
    logic [`RV64_XLEN-1:0] rd_shifted;
    logic [`RV64_XLEN-1:0] load_data;

    assign byte_off = alu_result[2:0];

    ////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////
    // Data is copied into every lane, the mask picks the live bytes
    always_comb begin
        case (mem_funct3[1:0])
            2'b00: begin
                mem_wr_data = {8{rs2_data[7:0]}};
                size_mask   = 8'b0000_0001;
            end
            2'b01: begin
                mem_wr_data = {4{rs2_data[15:0]}};
                size_mask   = 8'b0000_0011;
            end
            2'b10: begin
                mem_wr_data = {2{rs2_data[31:0]}};
                size_mask   = 8'b0000_1111;
            end
            default: begin
                mem_wr_data = rs2_data;
                size_mask   = 8'b1111_1111;
            end
        endcase
    end

    assign mem_wr_mask = mem_wen ? size_mask << byte_off : 8'h00;

    ////////////////////////////////////////
    // Load extract and writeback select
    ////////////////////////////////////////
    assign rd_shifted = mem_rd_data >> {byte_off, 3'b000};

    always_comb begin
        case (mem_funct3)
            3'b000:  load_data = {{(`RV64_XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            3'b001:  load_data = {{(`RV64_XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            3'b010:  load_data = {{(`RV64_XLEN-32){rd_shifted[31]}}, rd_shifted[31:0]};
            3'b100:  load_data = {{(`RV64_XLEN-8){1'b0}}, rd_shifted[7:0]};
            3'b101:  load_data = {{(`RV64_XLEN-16){1'b0}}, rd_shifted[15:0]};
            3'b110:  load_data = {{(`RV64_XLEN-32){1'b0}}, rd_shifted[31:0]};
            default: load_data = rd_shifted;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_LOAD: wr_data = load_data;
            WB_PC4:  wr_data = pc_plus4;
            default: wr_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module pc_unit (
    input  wire                         sys_clk,
    input  wire                         rst_n,
    input  wire rv64_pkg::pc_sel_e      pc_sel,
    input  wire  [`RV64_XLEN-1:0]       alu_result,
    input  wire                         take_branch,
    output logic [`RV64_XLEN-1:0]       pc,
    output logic [`RV64_XLEN-1:0]       pc_plus4
);
    import rv64_pkg::*;

    logic [`RV64_XLEN-1:0] next_pc;

    assign pc_plus4 = pc + {{(`RV64_XLEN-3){1'b0}}, 3'b100};

    // Target only wins for a taken branch or JAL
    always_comb begin
        case (pc_sel)
            PC_TARGET: next_pc = take_branch ? alu_result : pc_plus4;
            PC_JALR:   next_pc = {alu_result[`RV64_XLEN-1:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV64_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv64_config.svh */
`ifndef RV64_CONFIG_SVH
`define RV64_CONFIG_SVH

// Data and address width
`define RV64_XLEN 64

// Architectural integer registers, x0 included
`define RV64_NUM_REGS 32

// First fetch address
`define RV64_RESET_PC 64'h0

`endif

/* hdl/rv64_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv64_config.svh"

module rv64_core (
    input  wire                     sys_clk,
    input  wire                     rst_n,
    input  wire  [31:0]             inst,
    input  wire  [`RV64_XLEN-1:0]   mem_rd_data,
    output logic [`RV64_XLEN-1:0]   pc,
    output logic                    mem_rd_en,
    output logic                    mem_wen,
    output logic [`RV64_XLEN-1:0]   mem_addr,
    output logic [`RV64_XLEN-1:0]   mem_wr_data,
    output logic [7:0]              mem_wr_mask
);
    import rv64_pkg::*;

    logic [`RV64_XLEN-1:0]               pc_plus4;
    logic [$clog2(`RV64_NUM_REGS)-1:0]   rs1_addr;
    logic [$clog2(`RV64_NUM_REGS)-1:0]   rs2_addr;
    logic [$clog2(`RV64_NUM_REGS)-1:0]   rd_addr;
    logic [`RV64_XLEN-1:0]               rs1_data;
    logic [`RV64_XLEN-1:0]               rs2_data;
    logic [`RV64_XLEN-1:0]               imm;
    logic [`RV64_XLEN-1:0]               alu_result;
    logic [`RV64_XLEN-1:0]               wr_data;
    alu_op_e                             alu_op;
    op1_sel_e                            op1_sel;
    op2_sel_e                            op2_sel;
    pc_sel_e                             pc_sel;
    wb_sel_e                             wb_sel;
    logic                                alu_word;
    logic                                take_branch;
    logic                                reg_wen;
    logic [2:0]                          mem_funct3;

    // Loads and stores address memory straight from the adder
    assign mem_addr = alu_result;

    ////////////////////////////////////////
    // Fetch side
    ////////////////////////////////////////
    pc_unit u_pc_unit (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .pc_sel      (pc_sel),
        .alu_result  (alu_result),
        .take_branch (take_branch),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    ////////////////////////////////////////
    // Decode, registers and execute
    ////////////////////////////////////////
    decoder u_decoder (
        .rst_n       (rst_n),
        .inst        (inst),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .imm         (imm),
        .alu_op      (alu_op),
        .alu_word    (alu_word),
        .op1_sel     (op1_sel),
        .op2_sel     (op2_sel),
        .pc_sel      (pc_sel),
        .take_branch (take_branch),
        .reg_wen     (reg_wen),
        .mem_rd_en   (mem_rd_en),
        .mem_wen     (mem_wen),
        .mem_funct3  (mem_funct3),
        .wb_sel      (wb_sel)
    );

    gpr_file u_gpr_file (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .wr_data  (wr_data),
        .reg_wen  (reg_wen),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .op1_sel    (op1_sel),
        .op2_sel    (op2_sel),
        .alu_op     (alu_op),
        .alu_word   (alu_word),
        .alu_result (alu_result)
    );

    ////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////
    mem_writeback u_mem_writeback (
        .alu_result  (alu_result),
        .rs2_data    (rs2_data),
        .pc_plus4    (pc_plus4),
        .mem_rd_data (mem_rd_data),
        .mem_funct3  (mem_funct3),
        .mem_wen     (mem_wen),
        .wb_sel      (wb_sel),
        .mem_wr_data (mem_wr_data),
        .mem_wr_mask (mem_wr_mask),
        .wr_data     (wr_data)
    );

endmodule

`default_nettype wire

/* hdl/rv64_pkg.sv */
`default_nettype none

package rv64_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    // PC_JALR takes the ALU result with bit 0 cleared
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_TARGET,
        PC_JALR
    } pc_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

endpackage

`default_nettype wire

/* rv64_core.f */
+incdir+hdl
hdl/rv64_pkg.sv
hdl/pc_unit.sv
hdl/decoder.sv
hdl/gpr_file.sv
hdl/alu.sv
hdl/mem_writeback.sv
hdl/rv64_core.sv
dv/rv64_core_tb.sv
